// File: verilog/la32_pkg.sv
package la32_pkg;

    // ==========================================================
    // Instruction word views
    // ==========================================================
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } la32_r3_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;                      // Also carries ui5 for the shifts
        logic [4:0]  rj;
        logic [4:0]  rd;
    } la32_i12_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        logic [4:0]  rd;
    } la32_i20_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [9:0]  offs_hi10;                 // Upper offset bits of b and bl
    } la32_offs_t;

    typedef union packed {
        la32_r3_t   r3;
        la32_i12_t  i12;
        la32_i20_t  i20;
        la32_offs_t of;
    } la32_inst_u;

    // ==========================================================
    // Opcodes, one width per view
    // ==========================================================
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_SLTU    = 17'h00025;
    localparam logic [16:0] OPC_NOR     = 17'h00028;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [16:0] OPC_SLLI_W  = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W  = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W  = 17'h00091;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W    = 10'h0a6;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;
    localparam logic [5:0]  OPC_JIRL    = 6'h13;
    localparam logic [5:0]  OPC_B       = 6'h14;
    localparam logic [5:0]  OPC_BL      = 6'h15;
    localparam logic [5:0]  OPC_BEQ     = 6'h16;
    localparam logic [5:0]  OPC_BNE     = 6'h17;

    // ==========================================================
    // ALU one-hot bit positions
    // ==========================================================
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;
    localparam int ALU_OP_W = 12;

    localparam int          DMEM_WORDS = 64;
    localparam logic [4:0]  LINK_REG   = 5'd1;

endpackage

// File: verilog/la32_ifs.sv
interface de_ex_if import la32_pkg::*; ();
    logic                valid;
    logic [31:0]         pc;
    logic [31:0]         src1;
    logic [31:0]         src2;
    logic [31:0]         store_data;
    logic [ALU_OP_W-1:0] alu_op;
    logic                mem_we;
    logic                res_from_mem;
    logic                gr_we;
    logic [4:0]          dest;

    modport source (
        output valid, pc, src1, src2, store_data, alu_op,
        output mem_we, res_from_mem, gr_we, dest
    );
    modport sink (
        input valid, pc, src1, src2, store_data, alu_op,
        input mem_we, res_from_mem, gr_we, dest
    );
endinterface

interface ex_wb_if ();
    logic        valid;
    logic [31:0] pc;
    logic [31:0] alu_result;
    logic [31:0] store_data;
    logic        mem_we;
    logic        res_from_mem;
    logic        gr_we;
    logic [4:0]  dest;

    modport source (
        output valid, pc, alu_result, store_data,
        output mem_we, res_from_mem, gr_we, dest
    );
    modport sink (
        input valid, pc, alu_result, store_data,
        input mem_we, res_from_mem, gr_we, dest
    );
endinterface

// File: verilog/la32_regfile.sv
module la32_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;                   // r0 is never written
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// File: verilog/la32_decode.sv
module la32_decode import la32_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst_pc,
    input  logic [31:0] inst_word,
    output logic        inst_ready,
    input  logic [4:0]  ex_busy_dest,               // Zero when execute writes nothing
    input  logic [4:0]  wb_busy_dest,               // Zero when result writes nothing
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic [4:0]  rf_raddr1,
    output logic [4:0]  rf_raddr2,
    input  logic [31:0] rf_rdata1,
    input  logic [31:0] rf_rdata2,
    de_ex_if.source     de
);

    logic                run;
    logic                dec_valid;
    logic [31:0]         dec_pc;
    la32_inst_u          dec_inst;
    logic                hazard;
    logic [ALU_OP_W-1:0] alu_op;
    logic [4:0]          rj;
    logic [4:0]          rd;
    logic [4:0]          rk;
    logic [25:0]         offs26;
    logic [31:0]         imm;
    logic [31:0]         br_offs;
    logic [31:0]         jirl_offs;
    logic                br_taken;
    logic                use_rj;
    logic                use_r2;
    logic                inst_3r;
    logic                inst_shift;
    logic                inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic                inst_nor, inst_and, inst_or, inst_xor;
    logic                inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w;
    logic                inst_ld_w, inst_st_w, inst_lu12i_w, inst_jirl;
    logic                inst_b, inst_bl, inst_beq, inst_bne;

    // ==========================================================
    // Decode register
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            run       <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (inst_ready)
                dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            dec_pc   <= inst_pc;
            dec_inst <= inst_word;
        end
    end

    assign inst_ready = run && (!dec_valid || !hazard);

    // ==========================================================
    // Instruction decode
    // ==========================================================
    assign inst_add_w   = dec_inst.r3.opcode == OPC_ADD_W;
    assign inst_sub_w   = dec_inst.r3.opcode == OPC_SUB_W;
    assign inst_slt     = dec_inst.r3.opcode == OPC_SLT;
    assign inst_sltu    = dec_inst.r3.opcode == OPC_SLTU;
    assign inst_nor     = dec_inst.r3.opcode == OPC_NOR;
    assign inst_and     = dec_inst.r3.opcode == OPC_AND;
    assign inst_or      = dec_inst.r3.opcode == OPC_OR;
    assign inst_xor     = dec_inst.r3.opcode == OPC_XOR;
    assign inst_slli_w  = dec_inst.r3.opcode == OPC_SLLI_W;
    assign inst_srli_w  = dec_inst.r3.opcode == OPC_SRLI_W;
    assign inst_srai_w  = dec_inst.r3.opcode == OPC_SRAI_W;
    assign inst_addi_w  = dec_inst.i12.opcode == OPC_ADDI_W;
    assign inst_ld_w    = dec_inst.i12.opcode == OPC_LD_W;
    assign inst_st_w    = dec_inst.i12.opcode == OPC_ST_W;
    assign inst_lu12i_w = dec_inst.i20.opcode == OPC_LU12I_W;
    assign inst_jirl    = dec_inst.of.opcode == OPC_JIRL;
    assign inst_b       = dec_inst.of.opcode == OPC_B;
    assign inst_bl      = dec_inst.of.opcode == OPC_BL;
    assign inst_beq     = dec_inst.of.opcode == OPC_BEQ;
    assign inst_bne     = dec_inst.of.opcode == OPC_BNE;

    assign inst_3r    = inst_add_w | inst_sub_w | inst_slt | inst_sltu |
                        inst_nor | inst_and | inst_or | inst_xor;
    assign inst_shift = inst_slli_w | inst_srli_w | inst_srai_w;

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_SUB]  = inst_sub_w;
        alu_op[ALU_SLT]  = inst_slt;
        alu_op[ALU_SLTU] = inst_sltu;
        alu_op[ALU_AND]  = inst_and;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or;
        alu_op[ALU_XOR]  = inst_xor;
        alu_op[ALU_SLL]  = inst_slli_w;
        alu_op[ALU_SRL]  = inst_srli_w;
        alu_op[ALU_SRA]  = inst_srai_w;
        alu_op[ALU_LUI]  = inst_lu12i_w;
        alu_op[ALU_ADD]  = ~|alu_op;                // Adds, memory, links and no-ops
    end

    assign rj = dec_inst.r3.rj;
    assign rd = dec_inst.r3.rd;
    assign rk = dec_inst.r3.rk;

    assign imm = (inst_jirl || inst_bl) ? 32'h4 :
                 inst_lu12i_w           ? {dec_inst.i20.si20, 12'b0} :
                 {{20{dec_inst.i12.si12[11]}}, dec_inst.i12.si12};

    // ==========================================================
    // Operands and interlock
    // ==========================================================
    assign use_rj    = inst_3r | inst_shift | inst_addi_w | inst_ld_w | inst_st_w |
                       inst_jirl | inst_beq | inst_bne;
    assign use_r2    = inst_3r | inst_st_w | inst_beq | inst_bne;
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_beq || inst_bne || inst_st_w) ? rd : rk;

    assign hazard = dec_valid && (
        (use_rj && rj != 5'd0 && (rj == ex_busy_dest || rj == wb_busy_dest)) ||
        (use_r2 && rf_raddr2 != 5'd0 &&
            (rf_raddr2 == ex_busy_dest || rf_raddr2 == wb_busy_dest)));

    // ==========================================================
    // Branch resolution
    // ==========================================================
    assign offs26    = {dec_inst.of.offs_hi10, dec_inst.of.offs16};
    assign jirl_offs = {{14{dec_inst.of.offs16[15]}}, dec_inst.of.offs16, 2'b0};
    assign br_offs   = (inst_b || inst_bl) ? {{4{offs26[25]}}, offs26, 2'b0} : jirl_offs;
    assign br_taken  = inst_b | inst_bl | inst_jirl |
                       (inst_beq && rf_rdata1 == rf_rdata2) |
                       (inst_bne && rf_rdata1 != rf_rdata2);

    assign redirect_valid = de.valid && br_taken;
    assign redirect_pc    = inst_jirl ? rf_rdata1 + jirl_offs : dec_pc + br_offs;

    // ==========================================================
    // Transfer to execute
    // ==========================================================
    assign de.valid        = dec_valid && !hazard;
    assign de.pc           = dec_pc;
    assign de.src1         = (inst_jirl || inst_bl) ? dec_pc : rf_rdata1;
    assign de.src2         = (inst_shift || inst_addi_w || inst_ld_w || inst_st_w ||
                              inst_lu12i_w || inst_jirl || inst_bl) ? imm : rf_rdata2;
    assign de.store_data   = rf_rdata2;
    assign de.alu_op       = alu_op;
    assign de.mem_we       = inst_st_w;
    assign de.res_from_mem = inst_ld_w;
    assign de.gr_we        = inst_3r | inst_shift | inst_addi_w | inst_ld_w |
                             inst_lu12i_w | inst_jirl | inst_bl;
    assign de.dest         = inst_bl ? LINK_REG : rd;

    // A stall never lasts more than two cycles
    assert property (@(posedge clk) disable iff (reset)
        hazard && $past(hazard) |=> !hazard);

endmodule

// File: verilog/la32_execute.sv
module la32_execute import la32_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    de_ex_if.sink   de,
    ex_wb_if.source ex
);

    logic                ex_valid;
    logic [31:0]         ex_pc;
    logic [31:0]         src1;
    logic [31:0]         src2;
    logic [31:0]         ex_store_data;
    logic [ALU_OP_W-1:0] op;
    logic                ex_mem_we;
    logic                ex_res_from_mem;
    logic                ex_gr_we;
    logic [4:0]          ex_dest;

    always_ff @(posedge clk) begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= de.valid;
    end

    always_ff @(posedge clk) begin
        if (de.valid) begin
            ex_pc           <= de.pc;
            src1            <= de.src1;
            src2            <= de.src2;
            ex_store_data   <= de.store_data;
            op              <= de.alu_op;
            ex_mem_we       <= de.mem_we;
            ex_res_from_mem <= de.res_from_mem;
            ex_gr_we        <= de.gr_we;
            ex_dest         <= de.dest;
        end
    end

    // ==========================================================
    // ALU, one-hot AND-OR select
    // ==========================================================
    assign ex.alu_result =
        ({32{op[ALU_ADD]}}  & (src1 + src2)) |
        ({32{op[ALU_SUB]}}  & (src1 - src2)) |
        ({32{op[ALU_SLT]}}  & {31'b0, $signed(src1) < $signed(src2)}) |
        ({32{op[ALU_SLTU]}} & {31'b0, src1 < src2}) |
        ({32{op[ALU_AND]}}  & (src1 & src2)) |
        ({32{op[ALU_NOR]}}  & ~(src1 | src2)) |
        ({32{op[ALU_OR]}}   & (src1 | src2)) |
        ({32{op[ALU_XOR]}}  & (src1 ^ src2)) |
        ({32{op[ALU_SLL]}}  & (src1 << src2[4:0])) |
        ({32{op[ALU_SRL]}}  & (src1 >> src2[4:0])) |
        ({32{op[ALU_SRA]}}  & 32'($signed(src1) >>> src2[4:0])) |
        ({32{op[ALU_LUI]}}  & src2);                // Immediate is already shifted

    assign ex.valid        = ex_valid;
    assign ex.pc           = ex_pc;
    assign ex.store_data   = ex_store_data;
    assign ex.mem_we       = ex_mem_we;
    assign ex.res_from_mem = ex_res_from_mem;
    assign ex.gr_we        = ex_gr_we;
    assign ex.dest         = ex_dest;

    // Decode always selects exactly one operation
    assert property (@(posedge clk) disable iff (reset) ex_valid |-> $onehot(op));

endmodule

// File: verilog/la32_result.sv
module la32_result import la32_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    ex_wb_if.sink       ex,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        commit_valid,
    output logic [31:0] commit_pc,
    output logic        commit_we,
    output logic [4:0]  commit_dest,
    output logic [31:0] commit_data
);

    logic                          wb_valid;
    logic [31:0]                   wb_pc;
    logic [31:0]                   wb_alu_result;
    logic [31:0]                   wb_store_data;
    logic                          wb_mem_we;
    logic                          wb_res_from_mem;
    logic                          wb_gr_we;
    logic [4:0]                    wb_dest;
    logic [31:0]                   dmem [DMEM_WORDS];
    logic [$clog2(DMEM_WORDS)-1:0] widx;

    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= ex.valid;
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            wb_pc           <= ex.pc;
            wb_alu_result   <= ex.alu_result;
            wb_store_data   <= ex.store_data;
            wb_mem_we       <= ex.mem_we;
            wb_res_from_mem <= ex.res_from_mem;
            wb_gr_we        <= ex.gr_we;
            wb_dest         <= ex.dest;
        end
    end

    // ==========================================================
    // Data memory, word addressed
    // ==========================================================
    assign widx = wb_alu_result[$clog2(DMEM_WORDS)+1:2];

    always_ff @(posedge clk) begin
        if (wb_valid && wb_mem_we)
            dmem[widx] <= wb_store_data;
    end

    assign rf_wdata = wb_res_from_mem ? dmem[widx] : wb_alu_result;
    assign rf_we    = wb_valid && wb_gr_we && wb_dest != 5'd0;
    assign rf_waddr = wb_dest;

    assign commit_valid = wb_valid;
    assign commit_pc    = wb_pc;
    assign commit_we    = wb_valid && wb_gr_we;     // High for r0 too, the write is dropped
    assign commit_dest  = wb_dest;
    assign commit_data  = rf_wdata;

    // Stores never write the register file
    assert property (@(posedge clk) disable iff (reset) rf_we |-> !wb_mem_we);

endmodule

// File: verilog/la32_core.sv
module la32_core (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst_pc,
    input  logic [31:0] inst_word,
    output logic        inst_ready,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        commit_valid,
    output logic [31:0] commit_pc,
    output logic        commit_we,
    output logic [4:0]  commit_dest,
    output logic [31:0] commit_data
);

    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [4:0]  ex_busy_dest;
    logic [4:0]  wb_busy_dest;

    de_ex_if de_ex ();
    ex_wb_if ex_wb ();

    // Pending writes seen by the interlock, zero means none
    assign ex_busy_dest = (ex_wb.valid && ex_wb.gr_we) ? ex_wb.dest : 5'd0;
    assign wb_busy_dest = rf_we ? rf_waddr : 5'd0;

    la32_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .inst_ready     (inst_ready),
        .ex_busy_dest   (ex_busy_dest),
        .wb_busy_dest   (wb_busy_dest),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .de             (de_ex.source)
    );

    la32_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .de    (de_ex.sink),
        .ex    (ex_wb.source)
    );

    la32_result u_result (
        .clk          (clk),
        .reset        (reset),
        .ex           (ex_wb.sink),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_we    (commit_we),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data)
    );

    la32_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

// File: verif/la32_checker.sv
module la32_checker import la32_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic        inst_ready,
    input  logic [31:0] inst_pc,
    input  logic [31:0] inst_word,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        commit_valid,
    input  logic [31:0] commit_pc,
    input  logic        commit_we,
    input  logic [4:0]  commit_dest,
    input  logic [31:0] commit_data,
    output int          accepted,
    output int          mismatches,
    output int          other_errors,
    output int          outstanding
);

    logic [31:0] regs [32];
    logic [31:0] mem [DMEM_WORDS];
    logic [31:0] exp_pc_q[$];
    logic        exp_we_q[$];
    logic [4:0]  exp_dest_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] exp_branch_q[$];
    logic [31:0] exp_target_q[$];
    logic        reset_q = 1'b0;

    initial begin
        accepted     = 0;
        mismatches   = 0;
        other_errors = 0;
        outstanding  = 0;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;                  // Matches the opening store phase
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %h got %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // ==========================================================
    // In-order reference model
    // ==========================================================
    task automatic model_step(input logic [31:0] pc, input la32_inst_u inst);
        logic [31:0] vj;
        logic [31:0] vk;
        logic [31:0] vd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] target;
        logic [4:0]  dest;
        logic        we;
        logic        taken;
        vj     = regs[inst.r3.rj];
        vk     = regs[inst.r3.rk];
        vd     = regs[inst.r3.rd];
        addr   = vj + {{20{inst.i12.si12[11]}}, inst.i12.si12};
        data   = '0;
        dest   = inst.r3.rd;
        we     = 1'b1;
        taken  = 1'b0;
        target = pc + {{14{inst.of.offs16[15]}}, inst.of.offs16, 2'b0};
        case (1'b1)
            inst.r3.opcode == OPC_ADD_W:    data = vj + vk;
            inst.r3.opcode == OPC_SUB_W:    data = vj - vk;
            inst.r3.opcode == OPC_SLT:      data = 32'($signed(vj) < $signed(vk));
            inst.r3.opcode == OPC_SLTU:     data = 32'(vj < vk);
            inst.r3.opcode == OPC_NOR:      data = ~(vj | vk);
            inst.r3.opcode == OPC_AND:      data = vj & vk;
            inst.r3.opcode == OPC_OR:       data = vj | vk;
            inst.r3.opcode == OPC_XOR:      data = vj ^ vk;
            inst.r3.opcode == OPC_SLLI_W:   data = vj << inst.r3.rk;
            inst.r3.opcode == OPC_SRLI_W:   data = vj >> inst.r3.rk;
            inst.r3.opcode == OPC_SRAI_W:   data = $signed(vj) >>> inst.r3.rk;
            inst.i12.opcode == OPC_ADDI_W:  data = addr;
            inst.i12.opcode == OPC_LD_W:    data = mem[addr[7:2]];
            inst.i20.opcode == OPC_LU12I_W: data = {inst.i20.si20, 12'b0};
            inst.i12.opcode == OPC_ST_W: begin
                mem[addr[7:2]] = vd;
                we             = 1'b0;
            end
            inst.of.opcode == OPC_JIRL: begin
                data   = pc + 32'd4;
                taken  = 1'b1;
                target = vj + {{14{inst.of.offs16[15]}}, inst.of.offs16, 2'b0};
            end
            inst.of.opcode == OPC_B || inst.of.opcode == OPC_BL: begin
                we     = inst.of.opcode == OPC_BL;
                data   = pc + 32'd4;
                dest   = LINK_REG;
                taken  = 1'b1;
                target = pc + {{4{inst.of.offs_hi10[9]}}, inst.of.offs_hi10,
                               inst.of.offs16, 2'b0};
            end
            inst.of.opcode == OPC_BEQ: begin
                we    = 1'b0;
                taken = vj == vd;
            end
            inst.of.opcode == OPC_BNE: begin
                we    = 1'b0;
                taken = vj != vd;
            end
            default: we = 1'b0;                        // Retires as a no-op
        endcase
        if (we && dest != 5'd0)
            regs[dest] = data;
        exp_pc_q.push_back(pc);
        exp_we_q.push_back(we);
        exp_dest_q.push_back(dest);
        exp_data_q.push_back(data);
        if (taken) begin
            exp_branch_q.push_back(pc);
            exp_target_q.push_back(target);
        end
        accepted++;
    endtask

    task automatic check_commit();
        logic [31:0] pc;
        if (exp_pc_q.size() == 0) begin
            $display("commit at pc %h arrived with no instruction outstanding", commit_pc);
            other_errors++;
        end else begin
            pc = exp_pc_q.pop_front();
            check_value("commit_pc", pc, commit_pc);
            check_value($sformatf("commit_we at pc %h", pc), 32'(exp_we_q[0]), 32'(commit_we));
            if (exp_we_q[0]) begin
                check_value($sformatf("commit_dest at pc %h", pc),
                            32'(exp_dest_q[0]), 32'(commit_dest));
                check_value($sformatf("commit_data at pc %h", pc), exp_data_q[0], commit_data);
            end
            void'(exp_we_q.pop_front());
            void'(exp_dest_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    endtask

    task automatic check_redirect();
        logic [31:0] pc;
        if (exp_target_q.size() == 0) begin
            $display("redirect to %h arrived with no taken branch outstanding", redirect_pc);
            other_errors++;
        end else begin
            pc = exp_branch_q.pop_front();
            check_value($sformatf("redirect_pc of branch at %h", pc),
                        exp_target_q.pop_front(), redirect_pc);
        end
    endtask

    always @(posedge clk) begin
        if (reset_q) begin                             // In reset or the cycle after it
            check_value("commit_valid near reset", 32'h0, 32'(commit_valid));
            check_value("redirect_valid near reset", 32'h0, 32'(redirect_valid));
            if (reset)
                check_value("inst_ready in reset", 32'h0, 32'(inst_ready));
        end
        reset_q <= reset;
        if (!reset) begin
            if (commit_valid === 1'b1)
                check_commit();
            if (redirect_valid === 1'b1)
                check_redirect();
            if (inst_valid && inst_ready)
                model_step(inst_pc, inst_word);
        end
        outstanding = exp_pc_q.size() + exp_target_q.size();
    end

endmodule

// File: verif/tb_la32.sv
module tb_la32 import la32_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst_pc;
    logic [31:0] inst_word;
    logic        inst_ready;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_we;
    logic [4:0]  commit_dest;
    logic [31:0] commit_data;
    int          accepted;
    int          mismatches;
    int          other_errors;
    int          outstanding;
    int          timeouts;
    logic        jump_pending;
    logic [31:0] jump_pc;
    logic [31:0] next_pc;

    la32_core dut (.*);

    la32_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // One clock edge, remembering the latest branch target
    task automatic tick();
        @(posedge clk);
        if (redirect_valid) begin
            jump_pending = 1'b1;
            jump_pc      = redirect_pc;
        end
    endtask

    task automatic offer(input logic [31:0] word);
        int waited;
        waited = 0;
        if (jump_pending) begin
            next_pc      = jump_pc;
            jump_pending = 1'b0;
        end
        inst_valid <= 1'b1;
        inst_pc    <= next_pc;
        inst_word  <= word;
        do begin
            tick();
            waited++;
        end while (!inst_ready && waited < 20);
        if (!inst_ready) begin
            $display("timeout: instruction at pc %h was not accepted within 20 cycles", next_pc);
            timeouts++;
        end
        next_pc    = next_pc + 32'd4;
        inst_valid <= 1'b0;
        repeat ($urandom_range(2)) tick();             // Random idle gap
    endtask

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [15:0] offs;
        rd   = 5'($urandom_range(7));                 // Few registers, many hazards
        rj   = 5'($urandom_range(7));
        rk   = 5'($urandom_range(7));
        offs = 16'($urandom_range(16)) - 16'd8;
        case ($urandom_range(20))
            0:  return {OPC_ADD_W, rk, rj, rd};
            1:  return {OPC_SUB_W, rk, rj, rd};
            2:  return {OPC_SLT, rk, rj, rd};
            3:  return {OPC_SLTU, rk, rj, rd};
            4:  return {OPC_NOR, rk, rj, rd};
            5:  return {OPC_AND, rk, rj, rd};
            6:  return {OPC_OR, rk, rj, rd};
            7:  return {OPC_XOR, rk, rj, rd};
            8:  return {OPC_SLLI_W, 5'($urandom), rj, rd};
            9:  return {OPC_SRLI_W, 5'($urandom), rj, rd};
            10: return {OPC_SRAI_W, 5'($urandom), rj, rd};
            11: return {OPC_ADDI_W, 12'($urandom), rj, rd};
            12: return {OPC_LD_W, 12'($urandom), rj, rd};
            13: return {OPC_ST_W, 12'($urandom), rj, rd};
            14: return {OPC_LU12I_W, 20'($urandom), rd};
            15: return {OPC_JIRL, offs, rj, rd};
            16: return {OPC_B, offs, {10{offs[15]}}};
            17: return {OPC_BL, offs, {10{offs[15]}}};
            18: return {OPC_BEQ, offs, rj, rd};
            19: return {OPC_BNE, offs, rj, rd};
            default: return {6'h3f, 26'($urandom)};     // Unsupported word
        endcase
    endfunction

    task automatic drain();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (outstanding != 0 && waited < 50);
        if (outstanding != 0) begin
            $display("timeout: %0d expected commits or redirects never arrived", outstanding);
            timeouts++;
        end
    endtask

    initial begin
        void'($urandom(61));
        reset        <= 1'b1;
        inst_valid   <= 1'b0;
        inst_pc      <= '0;
        inst_word    <= '0;
        jump_pending = 1'b0;
        jump_pc      = '0;
        next_pc      = 32'h1c00_0000;
        timeouts     = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // ==========================================================
        // Clear every data word, then the random stream
        // ==========================================================
        for (int k = 0; k < DMEM_WORDS && timeouts == 0; k++)
            offer({OPC_ST_W, 12'(k * 4), 5'd0, 5'd0});
        for (int n = 0; n < 2000 && timeouts == 0; n++)
            offer(random_inst());
        drain();

        $display("tb_la32: %0d accepted, %0d mismatches, %0d other errors, %0d timeouts",
                 accepted, mismatches, other_errors, timeouts);
        if (mismatches + other_errors + timeouts == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: verilog.f
verilog/la32_pkg.sv
verilog/la32_ifs.sv
verilog/la32_regfile.sv
verilog/la32_decode.sv
verilog/la32_execute.sv
verilog/la32_result.sv
verilog/la32_core.sv
verif/la32_checker.sv
verif/tb_la32.sv
